// ==== files.f ====
rtl/core_pkg.sv
rtl/imem.sv
rtl/fetch.sv
rtl/insn_queue.sv
rtl/decode.sv
rtl/fetch_top.sv
verification/fetch_sva.sv
verification/fetch_tb.sv

// ==== Bender.yml ====
package:
  name: fetch_front

sources:
  - files:
      - rtl/core_pkg.sv
      - rtl/imem.sv
      - rtl/fetch.sv
      - rtl/insn_queue.sv
      - rtl/decode.sv
      - rtl/fetch_top.sv
  - target: test
    files:
      - verification/fetch_sva.sv
      - verification/fetch_tb.sv

// ==== verification/fetch_tb.sv ====
`timescale 1ns/100ps

module fetch_tb;

  localparam int mem_words = 256;
  localparam int load_w = $clog2(mem_words);
  localparam int queue_depth = 4;
  localparam int reset_cycles = 10;
  // every program is padded to this many words and loaded during reset
  localparam int prog_words = 10;
  localparam int n_tests = 6;
  localparam int run_limit = prog_words * 40;
  // idle cycles after each program in which decode must stay quiet
  localparam int drain_cycles = 8;
  localparam int timeout_cycles =
    n_tests * (run_limit + reset_cycles + drain_cycles + 1) + 20;

  logic in_clk;
  logic in_rst;
  logic load_en;
  logic [load_w-1:0] load_addr;
  logic [core_pkg::insn_w-1:0] load_data;
  logic hold;
  logic dec_valid;
  logic [core_pkg::addr_w-1:0] dec_pc;
  logic [core_pkg::insn_w-1:0] dec_insn;
  core_pkg::opcode_t dec_opcode;
  logic [core_pkg::reg_w-1:0] dec_rd;
  logic [core_pkg::addr_w-1:0] dec_imm;
  logic done;

  // program image and the fields each word was built with
  logic [core_pkg::insn_w-1:0] prog_word [prog_words];
  core_pkg::opcode_t prog_op [prog_words];
  logic [core_pkg::reg_w-1:0] prog_rd [prog_words];
  logic [core_pkg::addr_w-1:0] prog_imm [prog_words];
  // expected decode stream in program order
  logic [core_pkg::addr_w-1:0] exp_pc [$];
  logic [core_pkg::insn_w-1:0] exp_insn [$];
  core_pkg::opcode_t exp_op [$];
  logic [core_pkg::reg_w-1:0] exp_rd [$];
  logic [core_pkg::addr_w-1:0] exp_imm [$];
  int errors;
  int cycles;
  logic [31:0] lfsr;

  fetch_top #(.MEM_WORDS(mem_words), .ENTRY_PC('0), .QUEUE_DEPTH(queue_depth)) fetch_top_inst (
    .in_clk(in_clk), .in_rst(in_rst), .load_en(load_en), .load_addr(load_addr),
    .load_data(load_data), .hold(hold), .dec_valid(dec_valid), .dec_pc(dec_pc),
    .dec_insn(dec_insn), .dec_opcode(dec_opcode), .dec_rd(dec_rd), .dec_imm(dec_imm),
    .done(done)
  );

  // queue occupancy lives inside the queue instance
  bind fetch_top fetch_sva #(.QUEUE_DEPTH(QUEUE_DEPTH)) queue_checks (
    .in_clk(in_clk), .in_rst(in_rst), .push(push), .pop(pop), .full(full),
    .empty(empty), .done(done), .count(insn_queue_inst.count)
  );

  initial begin
    in_clk = 1'b0;
    forever #10 in_clk = ~in_clk;
  end

  // watchdog over the whole run
  initial begin
    cycles = 0;
    while (cycles < timeout_cycles) begin
      @(posedge in_clk);
      cycles++;
    end
    $display("timeout after %0d cycles, %0d words still expected", cycles, exp_pc.size());
    $display("*** TEST FAILED ***");
    $finish;
  end

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha3000000) : (lfsr >> 1);
    end
    return val;
  endfunction

  task automatic clear_prog();
    for (int i = 0; i < prog_words; i++) begin
      put(i, '0, core_pkg::OP_NONE, '0, '0);
    end
  endtask

  task automatic put(input int idx, input logic [31:0] word, input core_pkg::opcode_t op,
                     input logic [4:0] rd, input logic [63:0] imm);
    prog_word[idx] = word;
    prog_op[idx] = op;
    prog_rd[idx] = rd;
    prog_imm[idx] = imm;
  endtask

  // add x<rd>, x<rn>, #imm12 with a random source register
  task automatic put_addi(input int idx, input logic [4:0] rd, input logic [11:0] imm12);
    put(idx, {10'b1001000100, imm12, 5'(rand_bits(5)), rd}, core_pkg::OP_ADDI, rd,
        64'(imm12));
  endtask

  task automatic put_movz(input int idx, input logic [4:0] rd, input logic [15:0] imm16,
                          input logic [1:0] hw);
    put(idx, {9'b110100101, hw, imm16, rd}, core_pkg::OP_MOVZ, rd,
        64'(imm16) << (16 * hw));
  endtask

  // offset in words, negative goes backward
  task automatic put_branch(input int idx, input bit link, input int off);
    put(idx, {link ? 6'b100101 : 6'b000101, off[25:0]},
        link ? core_pkg::OP_BL : core_pkg::OP_B, link ? 5'd30 : 5'd0, 64'(longint'(off) * 4));
  endtask

  task automatic put_nop(input int idx);
    put(idx, 32'hd503201f, core_pkg::OP_NOP, '0, '0);
  endtask

  // walk the image from the entry pc, branches always taken
  task automatic build_expected();
    logic [63:0] pc;
    int idx;
    pc = '0;
    exp_pc.delete();
    exp_insn.delete();
    exp_op.delete();
    exp_rd.delete();
    exp_imm.delete();
    for (int steps = 0; steps < 4 * prog_words; steps++) begin
      idx = int'(pc >> 2);
      if (idx >= prog_words || prog_word[idx] == '0) break;
      exp_pc.push_back(pc);
      exp_insn.push_back(prog_word[idx]);
      exp_op.push_back(prog_op[idx]);
      exp_rd.push_back(prog_rd[idx]);
      exp_imm.push_back(prog_imm[idx]);
      if (prog_op[idx] == core_pkg::OP_B || prog_op[idx] == core_pkg::OP_BL) pc += prog_imm[idx];
      else pc += 64'd4;
    end
  endtask

  // one word per reset cycle through the load port
  task automatic reset_and_load();
    for (int i = 0; i < reset_cycles; i++) begin
      @(posedge in_clk);
      #2;
      in_rst = 1'b1;
      hold = 1'b0;
      load_en = 1'b1;
      load_addr = load_w'(i);
      load_data = prog_word[i];
    end
    @(posedge in_clk);
    #2;
    in_rst = 1'b0;
    load_en = 1'b0;
  endtask

  task automatic compare_addr(input string name, input string field,
                              input logic [core_pkg::addr_w-1:0] expected,
                              input logic [core_pkg::addr_w-1:0] actual);
    if (actual !== expected) begin
      $display("** Error %s %s: expected %h, actual %h", name, field, expected, actual);
      errors++;
    end
  endtask

  task automatic compare_insn(input string name, input logic [core_pkg::insn_w-1:0] expected,
                              input logic [core_pkg::insn_w-1:0] actual);
    if (actual !== expected) begin
      $display("** Error %s insn: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic compare_opcode(input string name, input core_pkg::opcode_t expected,
                                input core_pkg::opcode_t actual);
    if (actual !== expected) begin
      $display("** Error %s opcode: expected %s, actual %s", name, expected.name(),
               actual.name());
      errors++;
    end
  endtask

  task automatic compare_reg(input string name, input logic [core_pkg::reg_w-1:0] expected,
                             input logic [core_pkg::reg_w-1:0] actual);
    if (actual !== expected) begin
      $display("** Error %s rd: expected %0d, actual %0d", name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_output(input string name);
    if (exp_pc.size() == 0) begin
      $display("%s: decode gave an unexpected word at pc %h", name, dec_pc);
      errors++;
    end else begin
      compare_addr(name, "pc", exp_pc.pop_front(), dec_pc);
      compare_insn(name, exp_insn.pop_front(), dec_insn);
      compare_opcode(name, exp_op.pop_front(), dec_opcode);
      compare_reg(name, exp_rd.pop_front(), dec_rd);
      compare_addr(name, "imm", exp_imm.pop_front(), dec_imm);
    end
  endtask

  // run until fetch halts and every expected word came out
  task automatic run_program(input string name, input bit use_hold);
    int run_len;
    int wait_cycles;
    run_len = 0;
    wait_cycles = 0;
    build_expected();
    reset_and_load();
    if (use_hold) begin
      // open with a stall long enough to fill the queue
      hold = 1'b1;
      run_len = queue_depth + 4;
    end
    while (!(done && exp_pc.size() == 0) && wait_cycles < run_limit) begin
      @(posedge in_clk);
      #2;
      wait_cycles++;
      if (use_hold) begin
        // random level held for 1 to 16 cycles, long ones fill the queue
        if (run_len == 0) begin
          hold = 1'(rand_bits(1));
          run_len = rand_bits(4) + 1;
        end
        run_len--;
      end
      if (dec_valid) check_output(name);
    end
    hold = 1'b0;
    // any word decode still gives now is repeated or stray
    repeat (drain_cycles) begin
      @(posedge in_clk);
      #2;
      if (dec_valid) check_output(name);
    end
    if (!done) begin
      $display("%s: fetch never raised done", name);
      errors++;
    end
    if (exp_pc.size() != 0) begin
      $display("%s: %0d expected words never came out of decode", name, exp_pc.size());
      errors++;
    end
  endtask

  task automatic test_sequential();
    clear_prog();
    put_addi(0, 5'd1, 12'(rand_bits(12)));
    put_movz(1, 5'd2, 16'(rand_bits(16)), 2'd0);
    put_nop(2);
    put_addi(3, 5'd3, 12'(rand_bits(12)));
    put_movz(4, 5'd4, 16'(rand_bits(16)), 2'd1);
    put_addi(5, 5'd31, 12'hfff);
    put_nop(6);
    run_program("sequential", 1'b0);
  endtask

  // same image as the sequential test, run right after it
  task automatic test_backpressure();
    run_program("backpressure", 1'b1);
  endtask

  task automatic test_forward_branch();
    clear_prog();
    put_addi(0, 5'd7, 12'(rand_bits(12)));
    put_branch(1, 1'b0, 3);
    // words 2, 3 and 6 are skipped
    put_addi(2, 5'd8, 12'h111);
    put_movz(3, 5'd9, 16'h2222, 2'd0);
    put_movz(4, 5'd10, 16'(rand_bits(16)), 2'd2);
    put_branch(5, 1'b0, 2);
    put_addi(6, 5'd11, 12'h333);
    put_nop(7);
    run_program("forward_branch", 1'b0);
  endtask

  // entry jumps to 4, then back to 1 and on to the zero at 3
  task automatic test_link_backward();
    clear_prog();
    put_branch(0, 1'b1, 4);
    put_addi(1, 5'd12, 12'(rand_bits(12)));
    put_nop(2);
    put_movz(4, 5'd13, 16'(rand_bits(16)), 2'd3);
    put_branch(5, 1'b1, -4);
    run_program("link_backward", 1'b0);
  endtask

  // words after the zero must never be fetched
  task automatic test_halt();
    clear_prog();
    put_addi(0, 5'd14, 12'(rand_bits(12)));
    put_nop(1);
    put_addi(3, 5'd15, 12'h0aa);
    put_movz(4, 5'd16, 16'h00bb, 2'd1);
    run_program("halt", 1'b0);
    repeat (20) begin
      @(posedge in_clk);
      #2;
      if (dec_valid || !done) begin
        $display("halt: decode output or done changed after the end of the program");
        errors++;
      end
    end
  endtask

  task automatic test_immediates();
    clear_prog();
    for (int hw = 0; hw < 4; hw++) begin
      put_movz(hw, 5'(rand_bits(5)), 16'(rand_bits(16)), 2'(hw));
    end
    // add x3, x1, x2 (register form) is outside the subset
    put(4, 32'h8b020023, core_pkg::OP_ERR, 5'd3, '0);
    run_program("immediates", 1'b0);
  endtask

  initial begin
    in_rst = 1'b1;
    load_en = 1'b0;
    load_addr = '0;
    load_data = '0;
    hold = 1'b0;
    errors = 0;
    lfsr = 32'h28bcadf6;
    test_sequential();
    test_backpressure();
    test_forward_branch();
    test_link_backward();
    test_halt();
    test_immediates();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== verification/fetch_sva.sv ====
`timescale 1ns/100ps

module fetch_sva #(
  parameter int QUEUE_DEPTH = 4
) (
  input logic                         in_clk,
  input logic                         in_rst,
  input logic                         push,
  input logic                         pop,
  input logic                         full,
  input logic                         empty,
  input logic                         done,
  input logic [$clog2(QUEUE_DEPTH):0] count
);

  // fetch stalls on full
  assert property (@(posedge in_clk) disable iff (in_rst) full |-> !push)
    else $error("fetch pushed into a full queue");

  // decode only takes a present word
  assert property (@(posedge in_clk) disable iff (in_rst) empty |-> !pop)
    else $error("decode popped an empty queue");

  assert property (@(posedge in_clk) disable iff (in_rst) count <= QUEUE_DEPTH)
    else $error("queue count above its depth");

  // halt is sticky, only reset clears it
  assert property (@(posedge in_clk) (done && !in_rst) |=> done)
    else $error("done fell while out of reset");

endmodule

// ==== rtl/fetch_top.sv ====
`timescale 1ns/100ps

module fetch_top #(
  parameter int                          MEM_WORDS   = 256,
  parameter logic [core_pkg::addr_w-1:0] ENTRY_PC    = '0,
  parameter int                          QUEUE_DEPTH = 4
) (
  input  logic                         in_clk,
  input  logic                         in_rst,
  input  logic                         load_en,
  input  logic [$clog2(MEM_WORDS)-1:0] load_addr,
  input  logic [core_pkg::insn_w-1:0]  load_data,
  input  logic                         hold,
  output logic                         dec_valid,
  output logic [core_pkg::addr_w-1:0]  dec_pc,
  output logic [core_pkg::insn_w-1:0]  dec_insn,
  output core_pkg::opcode_t            dec_opcode,
  output logic [core_pkg::reg_w-1:0]   dec_rd,
  output logic [core_pkg::addr_w-1:0]  dec_imm,
  output logic                         done
);

  // fetch to memory
  logic [core_pkg::addr_w-1:0] mem_addr;
  logic [core_pkg::insn_w-1:0] mem_data;
  // fetch to queue
  logic push;
  logic full;
  logic [core_pkg::addr_w-1:0] push_pc;
  logic [core_pkg::insn_w-1:0] push_insn;
  // queue to decode
  logic pop;
  logic empty;
  logic [core_pkg::addr_w-1:0] head_pc;
  logic [core_pkg::insn_w-1:0] head_insn;

  imem #(.MEM_WORDS(MEM_WORDS)) imem_inst (
    .in_clk(in_clk), .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
    .mem_addr(mem_addr), .mem_data(mem_data)
  );

  fetch #(.MEM_WORDS(MEM_WORDS), .ENTRY_PC(ENTRY_PC)) fetch_inst (
    .in_clk(in_clk), .in_rst(in_rst), .full(full), .mem_data(mem_data),
    .mem_addr(mem_addr), .push(push), .done(done), .push_pc(push_pc), .push_insn(push_insn)
  );

  insn_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) insn_queue_inst (
    .in_clk(in_clk), .in_rst(in_rst), .push(push), .pop(pop),
    .push_pc(push_pc), .push_insn(push_insn), .full(full), .empty(empty),
    .head_pc(head_pc), .head_insn(head_insn)
  );

  decode decode_inst (
    .in_clk(in_clk), .in_rst(in_rst), .empty(empty), .hold(hold),
    .head_pc(head_pc), .head_insn(head_insn), .pop(pop), .dec_valid(dec_valid),
    .dec_pc(dec_pc), .dec_insn(dec_insn), .dec_opcode(dec_opcode),
    .dec_rd(dec_rd), .dec_imm(dec_imm)
  );

endmodule

// ==== rtl/decode.sv ====
`timescale 1ns/100ps

module decode (
  input  logic                        in_clk,
  input  logic                        in_rst,
  input  logic                        empty,
  input  logic                        hold,
  input  logic [core_pkg::addr_w-1:0] head_pc,
  input  logic [core_pkg::insn_w-1:0] head_insn,
  output logic                        pop,
  output logic                        dec_valid,
  output logic [core_pkg::addr_w-1:0] dec_pc,
  output logic [core_pkg::insn_w-1:0] dec_insn,
  output core_pkg::opcode_t           dec_opcode,
  output logic [core_pkg::reg_w-1:0]  dec_rd,
  output logic [core_pkg::addr_w-1:0] dec_imm
);

  core_pkg::opcode_t op;
  logic [core_pkg::reg_w-1:0] rd;

  // take the head word unless held from outside
  assign pop = !empty && !hold;

  assign op = core_pkg::classify(head_insn);

  // destination register per opcode
  always_comb begin
    case (op)
      // BL writes the link register x30
      core_pkg::OP_BL: rd = core_pkg::reg_w'(30);
      core_pkg::OP_B,
      core_pkg::OP_NOP: rd = '0;
      default: rd = head_insn[4:0];
    endcase
  end

  // strobe follows the pop by one cycle
  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= pop;
    end
  end

  // decoded fields, loaded only on a pop
  always_ff @(posedge in_clk) begin
    if (pop) begin
      dec_pc <= head_pc;
      dec_insn <= head_insn;
      dec_opcode <= op;
      dec_rd <= rd;
      dec_imm <= core_pkg::imm_value(head_insn, op);
    end
  end

endmodule

// ==== rtl/insn_queue.sv ====
`timescale 1ns/100ps

module insn_queue #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                        in_clk,
  input  logic                        in_rst,
  input  logic                        push,
  input  logic                        pop,
  input  logic [core_pkg::addr_w-1:0] push_pc,
  input  logic [core_pkg::insn_w-1:0] push_insn,
  output logic                        full,
  output logic                        empty,
  output logic [core_pkg::addr_w-1:0] head_pc,
  output logic [core_pkg::insn_w-1:0] head_insn
);

  localparam int ptr_w = $clog2(QUEUE_DEPTH);

  logic [core_pkg::addr_w-1:0] pc_mem   [QUEUE_DEPTH];
  logic [core_pkg::insn_w-1:0] insn_mem [QUEUE_DEPTH];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  // needs one bit more than the pointers to hold QUEUE_DEPTH
  logic [ptr_w:0] count;
  logic do_push;
  logic do_pop;

  assign full = (count == (ptr_w + 1)'(QUEUE_DEPTH));
  assign empty = (count == '0);

  // a pop in the same cycle frees the slot for a push into a full queue
  assign do_push = push && (!full || pop);
  assign do_pop = pop && !empty;

  // head is valid whenever empty is low
  assign head_pc = pc_mem[rd_ptr];
  assign head_insn = insn_mem[rd_ptr];

  // storage, no reset
  always_ff @(posedge in_clk) begin
    if (do_push) begin
      pc_mem[wr_ptr] <= push_pc;
      insn_mem[wr_ptr] <= push_insn;
    end
  end

  // pointers wrap naturally, depth is a power of two
  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// ==== rtl/fetch.sv ====
`timescale 1ns/100ps

module fetch #(
  parameter int                          MEM_WORDS = 256,
  parameter logic [core_pkg::addr_w-1:0] ENTRY_PC  = '0
) (
  input  logic                        in_clk,
  input  logic                        in_rst,
  input  logic                        full,
  input  logic [core_pkg::insn_w-1:0] mem_data,
  output logic [core_pkg::addr_w-1:0] mem_addr,
  output logic                        push,
  output logic                        done,
  output logic [core_pkg::addr_w-1:0] push_pc,
  output logic [core_pkg::insn_w-1:0] push_insn
);

  logic [core_pkg::addr_w-1:0] pc;
  logic [core_pkg::addr_w-1:0] next_pc;
  // set one cycle after reset, keeps push low during reset
  logic run;
  logic in_range;
  logic end_word;
  core_pkg::opcode_t op;

  // memory sees the pc directly
  assign mem_addr = pc;

  assign in_range = (pc >> 2) < core_pkg::addr_w'(MEM_WORDS);
  assign op = core_pkg::classify(mem_data);

  // zero word or running off the memory ends the program
  assign end_word = !in_range || (op == core_pkg::OP_NONE);

  // static prediction: B and BL always taken
  always_comb begin
    if (op == core_pkg::OP_B || op == core_pkg::OP_BL) begin
      next_pc = pc + core_pkg::branch_offset(mem_data);
    end else begin
      next_pc = pc + core_pkg::addr_w'(4);
    end
  end

  // one strobe per cycle while not stalled
  assign push = run && !done && !full && !end_word;
  assign push_pc = pc;
  assign push_insn = mem_data;

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      pc <= ENTRY_PC;
      run <= 1'b0;
      done <= 1'b0;
    end else begin
      run <= 1'b1;
      // sticky until the next reset
      if (run && !done && end_word) begin
        done <= 1'b1;
      end
      // full freezes the pc along with push
      if (push) begin
        pc <= next_pc;
      end
    end
  end

endmodule

// ==== rtl/imem.sv ====
`timescale 1ns/100ps

module imem #(
  parameter int MEM_WORDS = 256
) (
  input  logic                          in_clk,
  input  logic                          load_en,
  input  logic [$clog2(MEM_WORDS)-1:0]  load_addr,
  input  logic [core_pkg::insn_w-1:0]   load_data,
  input  logic [core_pkg::addr_w-1:0]   mem_addr,
  output logic [core_pkg::insn_w-1:0]   mem_data
);

  localparam int idx_w = $clog2(MEM_WORDS);

  logic [core_pkg::insn_w-1:0] words [MEM_WORDS];
  // byte address to word index
  logic [core_pkg::addr_w-3:0] word_idx;

  // program load, only used while the core is held in reset
  always_ff @(posedge in_clk) begin
    if (load_en) begin
      words[load_addr] <= load_data;
    end
  end

  assign word_idx = mem_addr[core_pkg::addr_w-1:2];

  // asynchronous read, out of range reads as the end marker
  always_comb begin
    if (word_idx < (core_pkg::addr_w - 2)'(MEM_WORDS)) begin
      mem_data = words[word_idx[idx_w-1:0]];
    end else begin
      mem_data = '0;
    end
  end

endmodule

// ==== rtl/core_pkg.sv ====
package core_pkg;

  // architectural widths
  localparam int addr_w = 64;
  localparam int insn_w = 32;
  localparam int reg_w = 5;

  // supported subset, OP_NONE marks the end of the program
  typedef enum logic [2:0] {
    OP_NONE,
    OP_B,
    OP_BL,
    OP_ADDI,
    OP_MOVZ,
    OP_NOP,
    OP_ERR
  } opcode_t;

  // opcode from the fixed encoding bits
  function automatic opcode_t classify(input logic [insn_w-1:0] insn);
    opcode_t op;
    if (insn == '0) op = OP_NONE;
    else if (insn[31:26] == 6'b000101) op = OP_B;
    else if (insn[31:26] == 6'b100101) op = OP_BL;
    // 64-bit add, no flags, unshifted imm12
    else if (insn[31:22] == 10'b1001000100) op = OP_ADDI;
    // 64-bit movz, any hw
    else if (insn[31:23] == 9'b110100101) op = OP_MOVZ;
    else if (insn == 32'hd503201f) op = OP_NOP;
    else op = OP_ERR;
    return op;
  endfunction

  // imm26 in words, sign extended to a byte offset
  function automatic logic [addr_w-1:0] branch_offset(input logic [insn_w-1:0] insn);
    return {{(addr_w - 28){insn[25]}}, insn[25:0], 2'b00};
  endfunction

  function automatic logic [addr_w-1:0] imm_value(input logic [insn_w-1:0] insn,
                                                   input opcode_t op);
    logic [addr_w-1:0] imm;
    case (op)
      OP_B, OP_BL: imm = branch_offset(insn);
      OP_ADDI: imm = addr_w'(insn[21:10]);
      // hw selects the 16-bit lane
      OP_MOVZ: imm = addr_w'(insn[20:5]) << {insn[22:21], 4'b0000};
      default: imm = '0;
    endcase
    return imm;
  endfunction

endpackage
